/* Makefile */
VERILATOR ?= verilator
TOP       ?= mrelbp_ci_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/mrelbp_cfg_pkg.sv */
`default_nettype none

package mrelbp_cfg_pkg;

  // window geometry
  localparam int WIN        = 13;  // window side, rows per slice and buffer depth
  localparam int CENTER_IDX = 6;   // middle row / middle column of the window

  // datapath widths
  localparam int PIX_W    = 8;
  localparam int COLSUM_W = 12;  // 13 * 255 = 3315
  localparam int WINSUM_W = 16;  // 169 * 255 = 43095

  // 169 * center, same range as the window sum
  localparam int SCALE_W = 16;

endpackage

`default_nettype wire

/* common/mrelbp_types_pkg.sv */
`default_nettype none

package mrelbp_types_pkg;
  import mrelbp_cfg_pkg::*;

  // one column slice, row 0 is the top of the band
  typedef logic [WIN-1:0][PIX_W-1:0] pix_col_t;

  typedef struct packed {
    logic band_first;  // first column of a band
    logic win_ready;   // column completes a full window
    logic band_last;
    logic frame_last;
  } col_tag_t;

  typedef struct packed {
    logic [COLSUM_W-1:0] colsum;
    logic [PIX_W-1:0]    mid_pix;  // row 6 of the column
    col_tag_t            tag;
  } col_entry_t;

  typedef struct packed {
    logic [WINSUM_W-1:0] winsum;
    logic [PIX_W-1:0]    center;  // pixel at the window center
    col_tag_t            tag;
  } win_t;

endpackage

`default_nettype wire

/* mrelbp_ci/ci_scan_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module ci_scan_ctrl
  import mrelbp_cfg_pkg::*;
  import mrelbp_types_pkg::*;
#(
  parameter int COLS = 15,
  parameter int ROWS = 15
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     col_valid,
  output col_tag_t col_tag
);

  localparam int COL_W = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] band_cnt;
  logic             last_col;
  logic             last_band;

  assign last_col  = (col_cnt == COL_W'(COLS - 1));
  assign last_band = (band_cnt == ROW_W'(ROWS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt  <= '0;
      band_cnt <= '0;
    end else if (col_valid) begin
      if (last_col) begin
        col_cnt <= '0;
        if (last_band) begin
          band_cnt <= '0;
        end else begin
          band_cnt <= band_cnt + 1'b1;
        end
      end else begin
        col_cnt <= col_cnt + 1'b1;
      end
    end
  end

  // position flags for the column currently on the input
  always_comb begin
    col_tag.band_first = (col_cnt == '0);
    col_tag.win_ready  = (int'(col_cnt) >= WIN - 1);  // columns 12 .. COLS-1
    col_tag.band_last  = last_col;
    col_tag.frame_last = last_col && last_band;
  end

endmodule

`default_nettype wire

/* mrelbp_ci/ci_threshold.sv */
`timescale 1ns/100ps
`default_nettype none

module ci_threshold
  import mrelbp_cfg_pkg::*;
  import mrelbp_types_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic win_valid,
  input  win_t win,
  output logic ci,
  output logic ci_valid,
  output logic band_done,
  output logic frame_done
);

  logic [SCALE_W-1:0] scaled;
  logic               take;

  // 169 = 128 + 32 + 8 + 1
  assign scaled = (SCALE_W'(win.center) << 7) + (SCALE_W'(win.center) << 5) +
                  (SCALE_W'(win.center) << 3) + SCALE_W'(win.center);

  assign take = win_valid && win.tag.win_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ci         <= 1'b0;
      ci_valid   <= 1'b0;
      band_done  <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      ci_valid   <= take;
      band_done  <= win_valid && win.tag.band_last;
      frame_done <= win_valid && win.tag.frame_last;
      if (take) begin
        ci <= (scaled >= win.winsum);  // center at least the window mean
      end
    end
  end

endmodule

`default_nettype wire

/* mrelbp_ci/column_adder.sv */
`timescale 1ns/100ps
`default_nettype none

module column_adder
  import mrelbp_cfg_pkg::*;
  import mrelbp_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       col_valid,
  input  pix_col_t   col_pix,
  input  col_tag_t   col_tag,
  output logic       entry_valid,
  output col_entry_t entry
);

  localparam int NPAIR = (WIN + 1) / 2;

  logic [PIX_W:0]      pair_sum [NPAIR];
  logic [COLSUM_W-1:0] col_sum;

  // first level of the tree, neighbouring rows in pairs
  for (genvar p = 0; p < NPAIR; p++) begin : g_pair
    if (2 * p + 1 < WIN) begin : g_two
      assign pair_sum[p] = col_pix[2*p] + col_pix[2*p+1];
    end else begin : g_one
      assign pair_sum[p] = {1'b0, col_pix[2*p]};  // odd row left over
    end
  end

  always_comb begin
    col_sum = '0;
    for (int p = 0; p < NPAIR; p++) begin
      col_sum = col_sum + COLSUM_W'(pair_sum[p]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= 1'b0;
    end else begin
      entry_valid <= col_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (col_valid) begin
      entry.colsum  <= col_sum;
      entry.mid_pix <= col_pix[CENTER_IDX];
      entry.tag     <= col_tag;
    end
  end

endmodule

`default_nettype wire

/* mrelbp_ci/mrelbp_ci_r6.sv */
`timescale 1ns/100ps
`default_nettype none

module mrelbp_ci_r6
  import mrelbp_types_pkg::*;
#(
  parameter int COLS = 15,
  parameter int ROWS = 15
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     col_valid,
  input  pix_col_t col_pix,
  output logic     ci,
  output logic     ci_valid,
  output logic     band_done,
  output logic     frame_done
);

  col_tag_t   col_tag;
  logic       entry_valid;
  col_entry_t entry;
  logic       win_valid;
  win_t       win;

  ci_scan_ctrl #(
    .COLS (COLS),
    .ROWS (ROWS)
  ) ci_scan_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .col_valid (col_valid),
    .col_tag   (col_tag)
  );

  column_adder column_adder_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .col_valid   (col_valid),
    .col_pix     (col_pix),
    .col_tag     (col_tag),
    .entry_valid (entry_valid),
    .entry       (entry)
  );

  window_accumulator window_accumulator_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .entry_valid (entry_valid),
    .entry       (entry),
    .win_valid   (win_valid),
    .win         (win)
  );

  ci_threshold ci_threshold_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_valid  (win_valid),
    .win        (win),
    .ci         (ci),
    .ci_valid   (ci_valid),
    .band_done  (band_done),
    .frame_done (frame_done)
  );

endmodule

`default_nettype wire

/* mrelbp_ci/window_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module window_accumulator
  import mrelbp_cfg_pkg::*;
  import mrelbp_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       entry_valid,
  input  col_entry_t entry,
  output logic       win_valid,
  output win_t       win
);

  // slot 0 holds the newest column
  logic [COLSUM_W-1:0] sum_q [WIN];
  logic [PIX_W-1:0]    mid_q [CENTER_IDX];  // middle pixels up to the window center
  logic [WIN-1:0]      slot_vld;  // slot holds a column of the current band

  logic [COLSUM_W-1:0] leaving;
  logic [WINSUM_W-1:0] next_sum;

  assign leaving = slot_vld[WIN-1] ? sum_q[WIN-1] : '0;

  // win.winsum doubles as the running sum
  always_comb begin
    if (entry.tag.band_first) begin
      next_sum = WINSUM_W'(entry.colsum);
    end else begin
      next_sum = win.winsum + WINSUM_W'(entry.colsum) - WINSUM_W'(leaving);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_vld  <= '0;
      win_valid <= 1'b0;
    end else begin
      win_valid <= entry_valid;
      if (entry_valid) begin
        if (entry.tag.band_first) begin
          slot_vld <= WIN'(1);  // older columns belong to the previous band
        end else begin
          slot_vld <= {slot_vld[WIN-2:0], 1'b1};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (entry_valid) begin
      sum_q[0] <= entry.colsum;
      mid_q[0] <= entry.mid_pix;
      for (int i = 1; i < WIN; i++) begin
        sum_q[i] <= sum_q[i-1];
      end
      for (int i = 1; i < CENTER_IDX; i++) begin
        mid_q[i] <= mid_q[i-1];
      end
      win.winsum <= next_sum;
      win.center <= mid_q[CENTER_IDX-1];  // slot 6 once the shift is done
      win.tag    <= entry.tag;
    end
  end

endmodule

`default_nettype wire

/* src.f */
common/mrelbp_cfg_pkg.sv
common/mrelbp_types_pkg.sv
mrelbp_ci/ci_scan_ctrl.sv
mrelbp_ci/column_adder.sv
mrelbp_ci/window_accumulator.sv
mrelbp_ci/ci_threshold.sv
mrelbp_ci/mrelbp_ci_r6.sv
verification/mrelbp_ci_properties.sv
verification/mrelbp_ci_tb.sv

/* verification/mrelbp_ci_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module mrelbp_ci_properties (
  input logic clk,
  input logic rst_n,
  input logic col_valid,
  input logic ci_valid,
  input logic band_done,
  input logic frame_done
);

  logic quiet;

  assign quiet = !ci_valid && !band_done && !frame_done;

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> quiet)
    else $error("output strobe after a reset cycle");

  a_release_quiet: assert property (@(posedge clk) (rst_n && !$past(rst_n)) |=> quiet)
    else $error("output strobe in the first cycle after reset release");

  a_band_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    band_done |=> !band_done)
    else $error("band_done held for more than one cycle");

  a_frame_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |=> !frame_done)
    else $error("frame_done held for more than one cycle");

  a_frame_in_band: assert property (@(posedge clk) disable iff (!rst_n)
    frame_done |-> band_done)
    else $error("frame_done without band_done");

  a_ci_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ci_valid) |-> $past(col_valid, 3))
    else $error("ci_valid rose without a column three cycles earlier");

endmodule

bind mrelbp_ci_r6 mrelbp_ci_properties mrelbp_ci_properties_i (
  .clk, .rst_n, .col_valid, .ci_valid, .band_done, .frame_done
);

`default_nettype wire

/* verification/mrelbp_ci_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mrelbp_ci_tb
  import mrelbp_cfg_pkg::*;
  import mrelbp_types_pkg::*;
();

  localparam int COLS_TB  = 20;
  localparam int ROWS_TB  = 3;
  localparam int FRAME    = COLS_TB * ROWS_TB;  // columns per frame
  localparam int PER_BAND = COLS_TB - WIN + 1;  // windows per band
  localparam int LAT      = 3;
  localparam int LIMIT    = 2 * 5 * FRAME + 200;  // five frames are sent

  logic     clk = 1'b0;
  logic     rst_n;
  logic     col_valid;
  pix_col_t col_pix;
  logic     ci;
  logic     ci_valid;
  logic     band_done;
  logic     frame_done;

  integer   seed = 32'hb8d8_dce7;
  int       cyc = 0;
  int       last_exp = 0;
  int       tb_col = 0;
  int       tb_band = 0;
  int       band_seen = 0;
  int       frame_seen = 0;
  int       ref_start = 0;
  pix_col_t frame_cols [FRAME];
  pix_col_t band_cols [COLS_TB];
  bit       exp_civ [LIMIT + LAT];  // expected outputs, indexed by cycle
  bit       exp_ci [LIMIT + LAT];
  bit       exp_band [LIMIT + LAT];
  bit       exp_frame [LIMIT + LAT];
  logic     ci_log [$];
  logic     exp_log [$];  // model ci, in the same order as ci_log

  mrelbp_ci_r6 #(.COLS(COLS_TB), .ROWS(ROWS_TB)) mrelbp_ci_r6_i (
    .clk, .rst_n, .col_valid, .col_pix, .ci, .ci_valid, .band_done, .frame_done
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: test did not finish within %0d cycles", LIMIT);
      stop_run();
    end
  end

  // outputs settle half a cycle before the falling edge
  always @(negedge clk) begin
    if (ci_valid !== exp_civ[cyc]) strobe_error("ci_valid", ci_valid);
    if (band_done !== exp_band[cyc]) strobe_error("band_done", band_done);
    if (frame_done !== exp_frame[cyc]) strobe_error("frame_done", frame_done);
    if (exp_civ[cyc]) begin
      check_value("ci", 32'(ci), 32'(exp_ci[cyc]));
      ci_log.push_back(ci);
      exp_log.push_back(exp_ci[cyc]);
    end
    if (band_done) band_seen++;
    if (frame_done) frame_seen++;
  end

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h in cycle %0d", name, got, exp, cyc);
      stop_run();
    end
  endtask

  task automatic strobe_error(input string name, input logic got);
    $display("%s %s strobe in cycle %0d", (got === 1'b1) ? "unexpected" : "missing",
             name, cyc);
    stop_run();
  endtask

  // drives one column and predicts what it triggers LAT cycles later
  task automatic send_column(input pix_col_t p);
    int sum;
    int k;
    int center;
    col_valid         = 1'b1;
    col_pix           = p;
    band_cols[tb_col] = p;
    if (tb_col >= WIN - 1) begin
      k   = tb_col - (WIN - 1);  // window covers columns k .. k+12
      sum = 0;
      for (int c = k; c <= tb_col; c++) begin
        for (int r = 0; r < WIN; r++) begin
          sum += int'(band_cols[c][r]);
        end
      end
      center             = int'(band_cols[k + CENTER_IDX][CENTER_IDX]);
      exp_civ[cyc + LAT] = 1'b1;
      exp_ci[cyc + LAT]  = (WIN * WIN * center >= sum);
    end
    if (tb_col == COLS_TB - 1) begin
      exp_band[cyc + LAT] = 1'b1;
      if (tb_band == ROWS_TB - 1) exp_frame[cyc + LAT] = 1'b1;
      tb_col  = 0;
      tb_band = (tb_band == ROWS_TB - 1) ? 0 : tb_band + 1;
    end else begin
      tb_col++;
    end
    last_exp = cyc + LAT;
    @(negedge clk);
    col_valid = 1'b0;
  endtask

  task automatic send_frame(input int gap_mask);
    int gap;
    for (int i = 0; i < FRAME; i++) begin
      send_column(frame_cols[i]);
      gap = $random(seed) & gap_mask;  // idle cycles before the next column
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic drain();
    while (cyc <= last_exp) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic fill_random();
    for (int i = 0; i < FRAME; i++) begin
      for (int r = 0; r < WIN; r++) begin
        frame_cols[i][r] = 8'($random(seed));
      end
    end
  endtask

  task automatic test_reset();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (10) @(negedge clk);  // monitor expects silence here
  endtask

  task automatic test_uniform();
    int first;
    first = ci_log.size();
    for (int i = 0; i < FRAME; i++) frame_cols[i] = {WIN{8'd97}};
    send_frame(0);
    drain();
    check_value("uniform ci count", ci_log.size() - first, ROWS_TB * PER_BAND);
    for (int j = first; j < ci_log.size(); j++) check_value("uniform ci", 32'(ci_log[j]), 1);
  endtask

  // bands 0 and 2 have a bright center over black, band 1 a dark center over gray
  task automatic test_center();
    int               first;
    logic [PIX_W-1:0] bg;
    logic [PIX_W-1:0] spot;
    first = ci_log.size();
    for (int i = 0; i < FRAME; i++) begin
      bg   = (i / COLS_TB == 1) ? 8'd200 : 8'd0;
      spot = (i / COLS_TB == 1) ? 8'd0 : 8'd255;
      frame_cols[i]             = {WIN{bg}};
      frame_cols[i][CENTER_IDX] = spot;
    end
    send_frame(0);
    drain();
    check_value("center ci count", ci_log.size() - first, ROWS_TB * PER_BAND);
    for (int j = 0; j < ROWS_TB * PER_BAND; j++) begin
      check_value("center ci", 32'(ci_log[first + j]), (j / PER_BAND == 1) ? 0 : 1);
    end
  endtask

  task automatic test_random();
    fill_random();
    ref_start = ci_log.size();
    send_frame(0);
    drain();
    check_value("random ci count", ci_log.size() - ref_start, ROWS_TB * PER_BAND);
  endtask

  task automatic test_gapped();
    int first;
    first = ci_log.size();
    send_frame(3);  // same frame as test_random
    drain();
    check_value("gapped ci count", ci_log.size() - first, ROWS_TB * PER_BAND);
    for (int j = 0; j < ROWS_TB * PER_BAND; j++) begin
      check_value("gapped ci", 32'(ci_log[first + j]), 32'(exp_log[ref_start + j]));
    end
  endtask

  task automatic test_pulses();
    int bands;
    int frames;
    bands  = band_seen;
    frames = frame_seen;
    fill_random();
    send_frame(0);
    drain();
    check_value("band_done count", band_seen - bands, ROWS_TB);
    check_value("frame_done count", frame_seen - frames, 1);
  endtask

  initial begin
    rst_n     = 1'b0;
    col_valid = 1'b0;
    col_pix   = '0;
    test_reset();
    test_uniform();
    test_center();
    test_random();
    test_gapped();
    test_pulses();
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire
